/* verilog/rv_pkg.sv */
// Shared widths, encodings and stage-register structs, imported by every core module
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [XLEN-1:0] RESET_ADDR = '0;
  localparam logic [31:0]     NOP_INSTR  = 32'h0000_0013; // addi x0, x0, 0

  // Major opcodes kept by this core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    AND    = 4'd2,
    OR     = 4'd3,
    XOR    = 4'd4,
    SLT    = 4'd5,
    SLTU   = 4'd6,
    SLL    = 4'd7,
    SRL    = 4'd8,
    SRA    = 4'd9,
    PASS_B = 4'd10  // LUI result
  } alu_op_e;

  // Operand source in decode
  typedef enum logic [1:0] {
    FWD_RF = 2'd0,
    FWD_EX = 2'd1,
    FWD_WB = 2'd2
  } fwd_sel_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;   // Operand B from immediate
    logic    link;      // A is PC, B is 4
    logic    reg_we;
    logic    is_branch;
    logic    branch_ne; // BNE when set, BEQ otherwise
    logic    is_jal;
  } ctrl_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
  } if_id_t;

  // PC rides along so that the retire port can report it
  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_we;
    alu_op_e               alu_op;
  } id_ex_t;

  // Writeback register, also the retire port
  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_we;
    logic [XLEN-1:0]       data;
  } retire_t;

endpackage

/* verilog/fetch_stage.sv */
// Fetch stage of the core: PC register, branch redirect and the fetch-to-decode register
`timescale 1ns/1ns

module fetch_stage (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     redirect_i,
  input  logic [rv_pkg::XLEN-1:0]  target_i,
  input  logic                     flush_i,
  output logic [rv_pkg::XLEN-1:0]  imem_addr_o,
  input  logic [31:0]              imem_data_i,
  output rv_pkg::if_id_t           if_id_o
);
  import rv_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_next;

  assign imem_addr_o = pc_q; // Memory answers in the same cycle
  assign pc_next     = redirect_i ? target_i : pc_q + XLEN'(4);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= RESET_ADDR;
    end else begin
      pc_q <= pc_next;
    end
  end

  // Word behind a taken branch becomes a bubble
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_id_o.valid <= 1'b0;
      if_id_o.pc    <= RESET_ADDR;
      if_id_o.instr <= NOP_INSTR;
    end else if (flush_i) begin
      if_id_o.valid <= 1'b0;
      if_id_o.pc    <= pc_q;
      if_id_o.instr <= NOP_INSTR;
    end else begin
      if_id_o.valid <= 1'b1;
      if_id_o.pc    <= pc_q;
      if_id_o.instr <= imem_data_i;
    end
  end

endmodule

/* verilog/reg_file.sv */
// Integer register file with two read ports and a write-through write port, used by decode
`timescale 1ns/1ns

module reg_file (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic                          we_i,
  input  logic [rv_pkg::XLEN-1:0]       wdata_i,
  output logic [rv_pkg::XLEN-1:0]       rdata1_o,
  output logic [rv_pkg::XLEN-1:0]       rdata2_o
);
  import rv_pkg::*;

  logic [XLEN-1:0] regs [1:31]; // x0 has no storage
  logic            wr_en;

  assign wr_en = we_i && (rd_i != '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // Same-cycle write shows up on the read ports
  assign rdata1_o = (rs1_i == '0) ? '0 : (wr_en && rd_i == rs1_i) ? wdata_i : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : (wr_en && rd_i == rs2_i) ? wdata_i : regs[rs2_i];

endmodule

/* verilog/decode_stage.sv */
// Decode stage: register read, immediates, forwarding muxes, branch resolution, ID/EX register
`timescale 1ns/1ns

module decode_stage (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  rv_pkg::if_id_t          if_id_i,
  input  rv_pkg::ctrl_t           ctrl_i,
  input  rv_pkg::opcode_e         imm_kind_i,
  input  rv_pkg::fwd_sel_e        fwd_a_i,
  input  rv_pkg::fwd_sel_e        fwd_b_i,
  input  logic [rv_pkg::XLEN-1:0] ex_result_i,
  input  rv_pkg::retire_t         wb_i,
  output logic                    branch_taken_o,
  output logic [rv_pkg::XLEN-1:0] target_o,
  output rv_pkg::id_ex_t          id_ex_o
);
  import rv_pkg::*;

  logic [31:0]     instr;
  logic [XLEN-1:0] rf_a, rf_b;
  logic [XLEN-1:0] rs1_val, rs2_val;
  logic [XLEN-1:0] imm_i, imm_u, imm_b, imm_j, imm;
  logic [XLEN-1:0] op_a, op_b;
  logic            ops_equal;

  assign instr = if_id_i.instr;

  reg_file reg_file_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .rs1_i    (instr[19:15]),
    .rs2_i    (instr[24:20]),
    .rd_i     (wb_i.rd),
    .we_i     (wb_i.valid & wb_i.reg_we),
    .wdata_i  (wb_i.data),
    .rdata1_o (rf_a),
    .rdata2_o (rf_b)
  );

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (imm_kind_i)
      OPC_OP_IMM: imm = imm_i;
      OPC_LUI:    imm = imm_u;
      OPC_BRANCH: imm = imm_b;
      OPC_JAL:    imm = imm_j;
      default:    imm = '0; // R-type has none
    endcase
  end

  // Forwarding muxes
  always_comb begin
    case (fwd_a_i)
      FWD_EX:  rs1_val = ex_result_i;
      FWD_WB:  rs1_val = wb_i.data;
      default: rs1_val = rf_a;
    endcase
    case (fwd_b_i)
      FWD_EX:  rs2_val = ex_result_i;
      FWD_WB:  rs2_val = wb_i.data;
      default: rs2_val = rf_b;
    endcase
  end

  assign ops_equal      = (rs1_val == rs2_val);
  assign branch_taken_o = if_id_i.valid &&
                          (ctrl_i.is_jal ||
                           (ctrl_i.is_branch && (ctrl_i.branch_ne ? !ops_equal : ops_equal)));
  assign target_o       = if_id_i.pc + imm; // B or J immediate

  assign op_a = ctrl_i.link ? if_id_i.pc : rs1_val;
  assign op_b = ctrl_i.link ? XLEN'(4) : (ctrl_i.use_imm ? imm : rs2_val);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_o <= '0;
    end else begin
      id_ex_o.valid  <= if_id_i.valid;
      id_ex_o.pc     <= if_id_i.pc;
      id_ex_o.a      <= op_a;
      id_ex_o.b      <= op_b;
      id_ex_o.rd     <= instr[11:7];
      id_ex_o.reg_we <= if_id_i.valid & ctrl_i.reg_we; // Bubbles never write
      id_ex_o.alu_op <= ctrl_i.alu_op;
    end
  end

endmodule

/* verilog/pipe_control.sv */
// Central control of the core: instruction decode, forwarding select and fetch flush
`timescale 1ns/1ns

module pipe_control (
  input  rv_pkg::if_id_t                if_id_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd_i,
  input  logic                          ex_we_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_i,
  input  logic                          wb_we_i,
  input  logic                          branch_taken_i,
  output rv_pkg::ctrl_t                 ctrl_o,
  output rv_pkg::opcode_e               imm_kind_o,
  output rv_pkg::fwd_sel_e              fwd_a_o,
  output rv_pkg::fwd_sel_e              fwd_b_o,
  output logic                          flush_if_o
);
  import rv_pkg::*;

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic                  funct7_b5;
  logic [REG_ADDR_W-1:0] rs1, rs2;
  alu_op_e               arith_op;

  assign opcode    = opcode_e'(if_id_i.instr[6:0]);
  assign funct3    = if_id_i.instr[14:12];
  assign funct7_b5 = if_id_i.instr[30];
  assign rs1       = if_id_i.instr[19:15];
  assign rs2       = if_id_i.instr[24:20];

  // funct3 to ALU op, shared by OP and OP_IMM
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == OPC_OP && funct7_b5) ? SUB : ADD;
      3'b001:  arith_op = SLL;
      3'b010:  arith_op = SLT;
      3'b011:  arith_op = SLTU;
      3'b100:  arith_op = XOR;
      3'b101:  arith_op = funct7_b5 ? SRA : SRL;
      3'b110:  arith_op = OR;
      default: arith_op = AND;
    endcase
  end

  always_comb begin
    ctrl_o     = '0; // Unknown words fall through as no-ops
    ctrl_o.alu_op = ADD;
    imm_kind_o = OPC_OP;
    case (opcode)
      OPC_OP: begin
        ctrl_o.alu_op = arith_op;
        ctrl_o.reg_we = 1'b1;
      end
      OPC_OP_IMM: begin
        ctrl_o.alu_op  = arith_op;
        ctrl_o.use_imm = 1'b1;
        ctrl_o.reg_we  = 1'b1;
        imm_kind_o     = OPC_OP_IMM;
      end
      OPC_LUI: begin
        ctrl_o.alu_op  = PASS_B;
        ctrl_o.use_imm = 1'b1;
        ctrl_o.reg_we  = 1'b1;
        imm_kind_o     = OPC_LUI;
      end
      OPC_BRANCH: begin
        ctrl_o.is_branch = (funct3[2:1] == 2'b00); // BEQ and BNE only
        ctrl_o.branch_ne = funct3[0];
        imm_kind_o       = OPC_BRANCH;
      end
      OPC_JAL: begin
        ctrl_o.is_jal = 1'b1;
        ctrl_o.link   = 1'b1; // pc + 4 into rd
        ctrl_o.reg_we = 1'b1;
        imm_kind_o    = OPC_JAL;
      end
      default: begin
      end
    endcase
  end

  // Youngest producer wins
  always_comb begin
    fwd_a_o = FWD_RF;
    fwd_b_o = FWD_RF;
    if (rs1 != '0) begin
      if (ex_we_i && ex_rd_i == rs1)      fwd_a_o = FWD_EX;
      else if (wb_we_i && wb_rd_i == rs1) fwd_a_o = FWD_WB;
    end
    if (rs2 != '0) begin
      if (ex_we_i && ex_rd_i == rs2)      fwd_b_o = FWD_EX;
      else if (wb_we_i && wb_rd_i == rs2) fwd_b_o = FWD_WB;
    end
  end

  assign flush_if_o = if_id_i.valid & branch_taken_i;

endmodule

/* verilog/execute_stage.sv */
// Execute stage: ALU and the writeback register that also serves as the retire port
`timescale 1ns/1ns

module execute_stage (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  rv_pkg::id_ex_t          id_ex_i,
  output logic [rv_pkg::XLEN-1:0] ex_result_o,
  output rv_pkg::retire_t         wb_o
);
  import rv_pkg::*;

  logic [XLEN-1:0] a, b;
  logic [4:0]      shamt;
  logic            lt_signed, lt_unsigned;

  assign a           = id_ex_i.a;
  assign b           = id_ex_i.b;
  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (id_ex_i.alu_op)
      ADD:     ex_result_o = a + b;
      SUB:     ex_result_o = a - b;
      AND:     ex_result_o = a & b;
      OR:      ex_result_o = a | b;
      XOR:     ex_result_o = a ^ b;
      SLT:     ex_result_o = {{(XLEN-1){1'b0}}, lt_signed};
      SLTU:    ex_result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      SLL:     ex_result_o = a << shamt;
      SRL:     ex_result_o = a >> shamt;
      SRA:     ex_result_o = $unsigned($signed(a) >>> shamt);
      PASS_B:  ex_result_o = b;
      default: ex_result_o = '0;
    endcase
  end

  // One retire strobe per valid instruction, no hold
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_o <= '0;
    end else begin
      wb_o.valid  <= id_ex_i.valid;
      wb_o.pc     <= id_ex_i.pc;
      wb_o.rd     <= id_ex_i.rd;
      wb_o.reg_we <= id_ex_i.valid & id_ex_i.reg_we;
      wb_o.data   <= ex_result_o;
    end
  end

endmodule

/* verilog/rv_core.sv */
// Top of the RV32I pipeline core, connecting fetch, decode, execute and the control unit
`timescale 1ns/1ns

module rv_core (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  output logic [rv_pkg::XLEN-1:0] imem_addr_o,
  input  logic [31:0]             imem_data_i,
  output rv_pkg::retire_t         retire_o
);
  import rv_pkg::*;

  if_id_t          if_id;
  id_ex_t          id_ex;
  retire_t         wb;
  ctrl_t           ctrl;
  opcode_e         imm_kind;
  fwd_sel_e        fwd_a, fwd_b;
  logic            branch_taken;
  logic            flush_if;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] ex_result;

  assign retire_o = wb;

  fetch_stage fetch_stage_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .redirect_i  (branch_taken),
    .target_i    (target),
    .flush_i     (flush_if),
    .imem_addr_o (imem_addr_o),
    .imem_data_i (imem_data_i),
    .if_id_o     (if_id)
  );

  pipe_control pipe_control_i (
    .if_id_i        (if_id),
    .ex_rd_i        (id_ex.rd),
    .ex_we_i        (id_ex.reg_we),
    .wb_rd_i        (wb.rd),
    .wb_we_i        (wb.reg_we),
    .branch_taken_i (branch_taken),
    .ctrl_o         (ctrl),
    .imm_kind_o     (imm_kind),
    .fwd_a_o        (fwd_a),
    .fwd_b_o        (fwd_b),
    .flush_if_o     (flush_if)
  );

  decode_stage decode_stage_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .if_id_i        (if_id),
    .ctrl_i         (ctrl),
    .imm_kind_i     (imm_kind),
    .fwd_a_i        (fwd_a),
    .fwd_b_i        (fwd_b),
    .ex_result_i    (ex_result),
    .wb_i           (wb),
    .branch_taken_o (branch_taken),
    .target_o       (target),
    .id_ex_o        (id_ex)
  );

  execute_stage execute_stage_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .id_ex_i     (id_ex),
    .ex_result_o (ex_result),
    .wb_o        (wb)
  );

endmodule

/* testbench/tb_rv_core.sv */
// Simulation top for rv_core that runs a seeded random program from a ROM against an ISA model
`timescale 1ns/1ns

module tb_rv_core;
  import rv_pkg::*;

  localparam int RETIRE_TIMEOUT = 20;     // Cycles allowed between two retires
  localparam int LOOP_IDX       = 62;     // Word holding the final jal x0, 0
  localparam int LOOP_HITS      = 3;

  logic            clk;
  logic            rst_n;
  logic [XLEN-1:0] imem_addr;
  logic [31:0]     imem_data;
  retire_t         retire;

  logic [31:0] rom [0:63];
  logic        is_marker [0:63];
  logic [31:0] mregs [0:31];   // Architectural registers of the model
  logic [31:0] mpc;
  integer      seed;
  int          errors;

  rv_core rv_core_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .retire_o    (retire)
  );

  assign imem_data = rom[imem_addr[7:2]]; // Same-cycle read

  always #10 clk = ~clk;

  function automatic logic [31:0] addi_word(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [4:0] rd);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // OP, OP_IMM or LUI on x0..x7 with legal funct7 only
  task automatic random_alu_word(output logic [31:0] w);
    logic [31:0] r;
    logic [6:0]  f7;
    logic [11:0] imm;
    r   = $random(seed);
    f7  = (r[12] && (r[11:9] == 3'd0 || r[11:9] == 3'd5)) ? 7'h20 : 7'h00;
    imm = (r[11:9] == 3'd1 || r[11:9] == 3'd5) ? {f7, r[24:20]} : r[31:20];
    case (r[14:13])
      2'd0:    w = {f7, 2'b0, r[8:6], 2'b0, r[5:3], r[11:9], 2'b0, r[2:0], 7'b0110011};
      2'd3:    w = {r[31:12], 2'b0, r[2:0], 7'b0110111};
      default: w = {imm, 2'b0, r[5:3], r[11:9], 2'b0, r[2:0], 7'b0010011};
    endcase
  endtask

  // One instruction of the ISA model in program order
  task automatic model_step(output logic [31:0] e_pc, output logic [4:0] e_rd,
                            output logic e_we, output logic [31:0] e_data, output string kind);
    logic [31:0] w, a, b, rs2v, imm_i, imm_b, imm_j, res, next;
    logic [4:0]  sh;
    logic [2:0]  f3;
    w     = rom[mpc[7:2]];
    f3    = w[14:12];
    a     = mregs[w[19:15]];
    rs2v  = mregs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    b     = (w[6:0] == 7'b0110011) ? rs2v : imm_i;
    sh    = b[4:0];
    e_pc  = mpc;
    e_rd  = w[11:7];
    e_we  = 1'b0;
    res   = '0;
    next  = mpc + 32'd4;
    kind  = "unknown";
    case (w[6:0])
      7'b0110011, 7'b0010011: begin
        kind = "alu";
        e_we = 1'b1;
        case (f3)
          3'd0:    res = (w[6:0] == 7'b0110011 && w[30]) ? a - b : a + b;
          3'd1:    res = a << sh;
          3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'd3:    res = (a < b) ? 32'd1 : 32'd0;
          3'd4:    res = a ^ b;
          3'd5:    res = w[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
          3'd6:    res = a | b;
          default: res = a & b;
        endcase
      end
      7'b0110111: begin
        kind = "lui";
        e_we = 1'b1;
        res  = {w[31:12], 12'b0};
      end
      7'b1101111: begin
        kind = "jal";
        e_we = 1'b1;
        res  = mpc + 32'd4;  // Link value
        next = mpc + imm_j;
      end
      7'b1100011: begin
        kind = "branch";
        if ((f3 == 3'd0 && a == rs2v) || (f3 == 3'd1 && a != rs2v)) next = mpc + imm_b;
      end
      default: begin
      end
    endcase
    if (e_we && e_rd != 5'd0) mregs[e_rd] = res;
    e_data = res;
    mpc    = next;
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [31:0] exp_v, input logic [31:0] act_v);
    assert (exp_v === act_v) else begin
      errors++;
      $display("MISMATCH %s %s: expected %h actual %h", test, field, exp_v, act_v);
    end
  endtask

  initial begin
    logic [31:0] e_pc, e_data;
    logic [4:0]  e_rd;
    logic        e_we;
    string       kind;
    int          wait_cycles;
    int          retires;
    int          loop_hits;
    logic        aborted;

    clk     = 1'b0;
    rst_n   = 1'b0;
    seed    = 72;
    errors  = 0;
    retires = 0;
    loop_hits = 0;
    aborted = 1'b0;

    // Random body first and fixed control flow on top
    for (int i = 0; i < 64; i++) begin
      random_alu_word(rom[i]);
      is_marker[i] = 1'b0;
    end
    rom[12] = addi_word(12'd5, 5'd0, 5'd1);
    rom[13] = addi_word(12'd3, 5'd0, 5'd2);
    rom[14] = branch_word(13'd8, 5'd1, 5'd2, 3'b001);  // bne taken with both operands forwarded
    rom[16] = branch_word(13'd8, 5'd1, 5'd2, 3'b000);  // beq falls through
    rom[27] = branch_word(13'd8, 5'd3, 5'd3, 3'b000);  // beq taken
    rom[29] = {12'h123, 5'd1, 3'b000, 5'd4, 7'b0001011}; // Unknown opcode with rd x4
    rom[30] = branch_word(13'd8, 5'd4, 5'd4, 3'b001);  // bne falls through
    rom[41] = jal_word(21'd8, 5'd5);
    rom[43] = {7'h00, 5'd5, 5'd5, 3'b000, 5'd6, 7'b0110011}; // add x6, x5, x5
    rom[44] = addi_word(12'h7ff, 5'd6, 5'd0);                // Nonzero result into x0
    rom[45] = {7'h00, 5'd0, 5'd0, 3'b000, 5'd7, 7'b0110011}; // x0 writer in EX
    rom[46] = {7'h00, 5'd0, 5'd0, 3'b000, 5'd7, 7'b0110011}; // x0 writer in WB
    rom[LOOP_IDX] = jal_word(21'd0, 5'd0);
    foreach (is_marker[i]) begin
      if (i == 15 || i == 28 || i == 42 || i == 63) begin
        rom[i]       = addi_word(12'hfff, 5'd0, 5'd7);
        is_marker[i] = 1'b1;
      end
    end
    for (int i = 0; i < 32; i++) mregs[i] = '0;
    mpc = RESET_ADDR;

    repeat (4) begin
      @(posedge clk);
      @(negedge clk);
      check_value("reset", "retire_valid", 32'd0, 32'(retire.valid));
      check_value("reset", "imem_addr", RESET_ADDR, imem_addr);
    end
    @(posedge clk);
    #2 rst_n = 1'b1;
    @(negedge clk);
    check_value("after_reset", "retire_valid", 32'd0, 32'(retire.valid));
    check_value("after_reset", "imem_addr", RESET_ADDR, imem_addr);

    while (loop_hits < LOOP_HITS && !aborted) begin
      wait_cycles = 0;
      @(negedge clk);
      while (!retire.valid && wait_cycles < RETIRE_TIMEOUT) begin
        wait_cycles++;
        @(negedge clk);
      end
      if (!retire.valid) begin
        $display("Timeout: no instruction retired within %0d cycles", RETIRE_TIMEOUT);
        errors++;
        aborted = 1'b1;
      end else begin
        if (retires == 0) check_value("first_retire", "pc", RESET_ADDR, retire.pc);
        model_step(e_pc, e_rd, e_we, e_data, kind);
        check_value(kind, "pc", e_pc, retire.pc);
        check_value(kind, "reg_we", 32'(e_we), 32'(retire.reg_we));
        if (e_we) begin
          check_value(kind, "rd", 32'(e_rd), 32'(retire.rd));
          check_value(kind, "data", e_data, retire.data);
        end
        assert (!is_marker[retire.pc[7:2]]) else begin
          errors++;
          $display("Skipped marker instruction at pc %h retired", retire.pc);
        end
        if (e_pc == 32'(LOOP_IDX * 4)) loop_hits++;
        retires++;
      end
    end

    $display("Retired %0d instructions, %0d errors", retires, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* compile.f */
verilog/rv_pkg.sv
verilog/fetch_stage.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/pipe_control.sv
verilog/execute_stage.sv
verilog/rv_core.sv
testbench/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the core with its testbench in Verilator, run it, decide pass or fail from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f compile.f \
  --top-module tb_rv_core \
  -o tb_rv_core \
  && ./obj_dir/tb_rv_core | tee sim.log \
  && grep -qx "No errors" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
